// ==== ao_peripheral_subsystem.f ====
bus_pkg.sv
ao_map_pkg.sv
obi_to_reg.sv
reg_demux.sv
soc_ctrl.sv
boot_rom.sv
fast_intr_ctrl.sv
ao_peripheral_subsystem.sv
ao_peripheral_subsystem_asserts.sv
tb_ao_peripheral_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, then searches the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f ao_peripheral_subsystem.f \
  --top-module tb_ao_peripheral_subsystem -o tb_sim \
  && ./obj_dir/tb_sim | tee sim.log \
  || { echo "Build or run error"; exit 1; }
grep -q "^Everything OK$" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== tb_ao_peripheral_subsystem.sv ====
// Table-driven testbench for the always-on peripheral subsystem.
// Issues OBI transfers back to back and checks each response and the output ports.

`timescale 1ns/100ps

module tb_ao_peripheral_subsystem;

  import bus_pkg::*;
  import ao_map_pkg::*;

  localparam int unsigned NUM_FI = 15;
  localparam logic [31:0] SOC_BASE = AO_BASE_ADDR;
  localparam logic [31:0] ROM_BASE = AO_BASE_ADDR + 32'h1000;
  localparam logic [31:0] FI_BASE  = AO_BASE_ADDR + 32'h2000;
  localparam logic [31:0] EXT_BASE = AO_BASE_ADDR + 32'h3000;

  typedef struct packed {
    logic              wr;
    logic [31:0]       addr;
    logic [31:0]       wdata;
    logic [3:0]        be;
    logic [NUM_FI-1:0] fi;
    logic [31:0]       exp_rdata;
    logic              exp_err;
  } row_t;

  logic              clk;
  logic              arst_n;
  obi_req_t          slave_req;
  obi_resp_t         slave_resp;
  logic              boot_select;
  logic              exit_valid;
  logic [31:0]       exit_value;
  logic [NUM_FI-1:0] fast_intr_in;
  logic [NUM_FI-1:0] fast_intr_out;
  reg_req_t          ext_req;
  reg_rsp_t          ext_rsp;
  logic [31:0]       ext_last_wdata;
  logic [3:0]        ext_last_wstrb;

  row_t rows[$];
  int   seed = 78;
  int   mismatch_cnt = 0;
  int   handshake_cnt = 0;
  int   cycles = 0;
  int   limit = 0;

  // Expected state of the output ports
  logic              exp_valid;
  logic [31:0]       exp_value;
  logic [NUM_FI-1:0] exp_pend;
  logic [NUM_FI-1:0] exp_en;

  ao_peripheral_subsystem ao_peripheral_subsystem_i (
    .clk_i            (clk),
    .arst_n_i         (arst_n),
    .slave_req_i      (slave_req),
    .slave_resp_o     (slave_resp),
    .boot_select_i    (boot_select),
    .exit_valid_o     (exit_valid),
    .exit_value_o     (exit_value),
    .fast_intr_i      (fast_intr_in),
    .fast_intr_o      (fast_intr_out),
    .ext_periph_req_o (ext_req),
    .ext_periph_rsp_i (ext_rsp)
  );

  bind ao_peripheral_subsystem ao_peripheral_subsystem_asserts #(
    .NumFastIntr (NumFastIntr)
  ) asserts_i (
    .clk_i,
    .arst_n_i,
    .slave_req_i,
    .slave_resp_o,
    .exit_valid_o,
    .fast_intr_o
  );

  // External peripheral answers with the inverted address
  assign ext_rsp.error = 1'b0;
  assign ext_rsp.rdata = ~ext_req.addr;

  always @(posedge clk) begin
    if (ext_req.valid && ext_req.write) begin
      ext_last_wdata <= ext_req.wdata;
      ext_last_wstrb <= ext_req.wstrb;
    end
  end

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Something failed");
      $finish;
    end
  end

  function automatic logic [31:0] strobe_mask(input logic [3:0] be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  task automatic add_row(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] be, input logic [NUM_FI-1:0] fi,
                         input logic [31:0] exp_rdata, input logic exp_err);
    row_t r;
    r = '{wr, addr, wdata, be, fi, exp_rdata, exp_err};
    rows.push_back(r);
  endtask

  task automatic build_table();
    logic [31:0] v;
    logic [31:0] m;
    add_row(1'b0, SOC_BASE + 32'(BOOT_ADDR_OFS), '0, 4'hF, '0, BOOT_ADDR_RESET, 1'b0);
    add_row(1'b0, FI_BASE + 32'(FI_ENABLE_OFS), '0, 4'hF, '0, 32'h0000_7FFF, 1'b0);
    add_row(1'b0, SOC_BASE + 32'(EXIT_VALID_OFS), '0, 4'hF, '0, '0, 1'b0);
    add_row(1'b1, SOC_BASE + 32'(EXIT_VALUE_OFS), 32'h1234_5678, 4'hF, '0, '0, 1'b0);
    add_row(1'b1, SOC_BASE + 32'(EXIT_VALUE_OFS), 32'hAABB_CCDD, 4'h3, '0, '0, 1'b0);
    add_row(1'b0, SOC_BASE + 32'(EXIT_VALUE_OFS), '0, 4'hF, '0, 32'h1234_CCDD, 1'b0);
    add_row(1'b1, SOC_BASE + 32'(EXIT_VALID_OFS), 32'h1, 4'hF, '0, '0, 1'b0);
    add_row(1'b0, SOC_BASE + 32'(BOOT_SEL_OFS), '0, 4'hF, '0, 32'h1, 1'b0);
    add_row(1'b1, SOC_BASE + 32'(BOOT_SEL_OFS), 32'h0, 4'hF, '0, '0, 1'b1);
    add_row(1'b0, ROM_BASE, '0, 4'hF, '0, BOOT_ROM_CONTENT[0], 1'b0);
    add_row(1'b0, ROM_BASE + 32'h14, '0, 4'hF, '0, BOOT_ROM_CONTENT[5], 1'b0);
    add_row(1'b0, ROM_BASE + 32'h3C, '0, 4'hF, '0, BOOT_ROM_CONTENT[15], 1'b0);
    add_row(1'b0, ROM_BASE + 32'h40, '0, 4'hF, '0, '0, 1'b0);
    add_row(1'b1, ROM_BASE + 32'h8, 32'hFFFF_FFFF, 4'hF, '0, '0, 1'b1);
    // Lines 0 and 2 pulse here and read as pending one row later
    add_row(1'b0, FI_BASE + 32'(FI_PENDING_OFS), '0, 4'hF, 15'h0005, '0, 1'b0);
    add_row(1'b0, FI_BASE + 32'(FI_PENDING_OFS), '0, 4'hF, '0, 32'h5, 1'b0);
    add_row(1'b1, FI_BASE + 32'(FI_CLEAR_OFS), 32'h1, 4'hF, '0, '0, 1'b0);
    add_row(1'b0, FI_BASE + 32'(FI_PENDING_OFS), '0, 4'hF, '0, 32'h4, 1'b0);
    add_row(1'b1, FI_BASE + 32'(FI_ENABLE_OFS), 32'h7FFB, 4'hF, '0, '0, 1'b0);
    add_row(1'b0, FI_BASE + 32'(FI_PENDING_OFS), '0, 4'hF, '0, 32'h4, 1'b0);
    add_row(1'b0, FI_BASE + 32'(FI_ENABLE_OFS), '0, 4'hF, '0, 32'h7FFB, 1'b0);
    add_row(1'b1, FI_BASE + 32'(FI_PENDING_OFS), 32'h0, 4'hF, '0, '0, 1'b1);
    add_row(1'b0, EXT_BASE + 32'h10, '0, 4'hF, '0, ~(EXT_BASE + 32'h10), 1'b0);
    add_row(1'b1, EXT_BASE + 32'h4, 32'hCAFE_F00D, 4'hC, '0, '0, 1'b0);
    add_row(1'b0, AO_BASE_ADDR + 32'h5000, '0, 4'hF, '0, UNMAPPED_RDATA, 1'b1);
    add_row(1'b0, 32'h3000_0000, '0, 4'hF, '0, UNMAPPED_RDATA, 1'b1);
    v = $random(seed);
    add_row(1'b1, SOC_BASE + 32'(EXIT_VALUE_OFS), v, 4'hF, '0, '0, 1'b0);
    add_row(1'b0, SOC_BASE + 32'(EXIT_VALUE_OFS), '0, 4'hF, '0, v, 1'b0);
    v = $random(seed);
    m = strobe_mask(4'b0110);
    add_row(1'b1, SOC_BASE + 32'(BOOT_ADDR_OFS), v, 4'b0110, '0, '0, 1'b0);
    add_row(1'b0, SOC_BASE + 32'(BOOT_ADDR_OFS), '0, 4'hF, '0,
            (BOOT_ADDR_RESET & ~m) | (v & m), 1'b0);
  endtask

  // Applies the effect of a finished row to the expected port state
  task automatic update_model(input row_t r);
    logic [31:0] m;
    m = strobe_mask(r.be);
    if (r.wr && r.addr == SOC_BASE + 32'(EXIT_VALID_OFS)) exp_valid = r.wdata[0];
    if (r.wr && r.addr == SOC_BASE + 32'(EXIT_VALUE_OFS)) begin
      exp_value = (exp_value & ~m) | (r.wdata & m);
    end
    if (r.wr && r.addr == FI_BASE + 32'(FI_CLEAR_OFS)) exp_pend = exp_pend & ~r.wdata[NUM_FI-1:0];
    if (r.wr && r.addr == FI_BASE + 32'(FI_ENABLE_OFS)) exp_en = r.wdata[NUM_FI-1:0];
    exp_pend = exp_pend | r.fi;
  endtask

  task automatic check_cycle(input int i);
    row_t p;
    if (i < rows.size()) begin
      assert (slave_resp.gnt) else begin
        $display("Handshake error: no gnt in the request cycle of row %0d", i);
        handshake_cnt++;
      end
    end
    if (i == 0) begin
      assert (!slave_resp.rvalid) else begin
        $display("Handshake error: rvalid seen before any request");
        handshake_cnt++;
      end
    end else begin
      p = rows[i-1];
      assert (slave_resp.rvalid) else begin
        $display("Handshake error: rvalid missing one cycle after the grant of row %0d", i - 1);
        handshake_cnt++;
      end
      assert (slave_resp.err == p.exp_err) else begin
        $display("MISMATCH at %0t: row %0d err %0b, expected %0b", $time, i - 1,
                 slave_resp.err, p.exp_err);
        mismatch_cnt++;
      end
      if (!p.wr) begin
        assert (slave_resp.rdata == p.exp_rdata) else begin
          $display("MISMATCH at %0t: row %0d rdata %h, expected %h", $time, i - 1,
                   slave_resp.rdata, p.exp_rdata);
          mismatch_cnt++;
        end
      end
      if (p.wr && p.addr[31:12] == EXT_BASE[31:12]) begin
        assert (ext_last_wdata == p.wdata && ext_last_wstrb == p.be) else begin
          $display("MISMATCH at %0t: external write data %h strobe %h, expected %h %h",
                   $time, ext_last_wdata, ext_last_wstrb, p.wdata, p.be);
          mismatch_cnt++;
        end
      end
    end
    assert (exit_valid == exp_valid && exit_value == exp_value &&
            fast_intr_out == (exp_pend & exp_en)) else begin
      $display("MISMATCH at %0t: ports valid %0b value %h intr %h, expected %0b %h %h",
               $time, exit_valid, exit_value, fast_intr_out, exp_valid, exp_value,
               exp_pend & exp_en);
      mismatch_cnt++;
    end
  endtask

  initial begin
    arst_n = 1'b0;
    slave_req = '0;
    boot_select = 1'b1;
    fast_intr_in = '0;
    exp_valid = 1'b0;
    exp_value = '0;
    exp_pend = '0;
    exp_en = '1;
    build_table();
    limit = 10 + 4 * rows.size();
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;
    // One extra pass drains the last response
    for (int i = 0; i <= rows.size(); i++) begin
      @(posedge clk);
      #1;
      if (i < rows.size()) begin
        slave_req = '{1'b1, rows[i].wr, rows[i].be, rows[i].addr, rows[i].wdata};
        fast_intr_in = rows[i].fi;
      end else begin
        slave_req = '0;
      end
      @(negedge clk);
      if (i > 0) update_model(rows[i-1]);
      check_cycle(i);
    end
    $display("Error counts: %0d mismatches, %0d handshake errors", mismatch_cnt, handshake_cnt);
    if (mismatch_cnt == 0 && handshake_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== ao_peripheral_subsystem_asserts.sv ====
// OBI handshake and reset checks for the subsystem top level.
// Attached to the top level with bind from the testbench.

`timescale 1ns/100ps

module ao_peripheral_subsystem_asserts #(
  parameter int unsigned NumFastIntr = 15
) (
  input logic                   clk_i,
  input logic                   arst_n_i,
  input bus_pkg::obi_req_t      slave_req_i,
  input bus_pkg::obi_resp_t     slave_resp_o,
  input logic                   exit_valid_o,
  input logic [NumFastIntr-1:0] fast_intr_o
);

  gnt_on_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slave_req_i.req |-> slave_resp_o.gnt)
    else $error("gnt missing while req is high");

  // rvalid follows every grant by one cycle and never appears alone
  rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    slave_resp_o.rvalid == $past(slave_req_i.req && slave_resp_o.gnt))
    else $error("rvalid does not follow the grant by exactly one cycle");

  outputs_in_reset: assert property (@(posedge clk_i)
    !arst_n_i |-> (!exit_valid_o && fast_intr_o == '0))
    else $error("exit_valid_o or fast_intr_o high during reset");

endmodule

// ==== ao_peripheral_subsystem.sv ====
// Always-on peripheral subsystem top level.
// One OBI slave port feeds SoC control, boot ROM, fast interrupts and an external port.

`timescale 1ns/100ps

module ao_peripheral_subsystem #(
  parameter int unsigned NumFastIntr = 15
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  bus_pkg::obi_req_t      slave_req_i,
  output bus_pkg::obi_resp_t     slave_resp_o,

  input  logic                   boot_select_i,
  output logic                   exit_valid_o,
  output logic [31:0]            exit_value_o,

  input  logic [NumFastIntr-1:0] fast_intr_i,
  output logic [NumFastIntr-1:0] fast_intr_o,

  output bus_pkg::reg_req_t      ext_periph_req_o,
  input  bus_pkg::reg_rsp_t      ext_periph_rsp_i
);

  import bus_pkg::*;
  import ao_map_pkg::*;

  reg_req_t periph_req;
  reg_rsp_t periph_rsp;

  reg_req_t [NUM_AO_TARGETS-1:0] ao_slv_req;
  reg_rsp_t [NUM_AO_TARGETS-1:0] ao_slv_rsp;

  // Page 3 leaves the subsystem
  assign ext_periph_req_o           = ao_slv_req[EXT_PERIPH_IDX];
  assign ao_slv_rsp[EXT_PERIPH_IDX] = ext_periph_rsp_i;

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .arst_n_i,
    .obi_req_i  (slave_req_i),
    .obi_resp_o (slave_resp_o),
    .reg_req_o  (periph_req),
    .reg_rsp_i  (periph_rsp)
  );

  reg_demux reg_demux_i (
    .in_req_i  (periph_req),
    .in_rsp_o  (periph_rsp),
    .out_req_o (ao_slv_req),
    .out_rsp_i (ao_slv_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i (ao_slv_req[SOC_CTRL_IDX]),
    .reg_rsp_o (ao_slv_rsp[SOC_CTRL_IDX]),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  boot_rom boot_rom_i (
    .reg_req_i (ao_slv_req[BOOTROM_IDX]),
    .reg_rsp_o (ao_slv_rsp[BOOTROM_IDX])
  );

  fast_intr_ctrl #(
    .NumFastIntr (NumFastIntr)
  ) fast_intr_ctrl_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i (ao_slv_req[FAST_INTR_CTRL_IDX]),
    .reg_rsp_o (ao_slv_rsp[FAST_INTR_CTRL_IDX]),
    .fast_intr_i,
    .fast_intr_o
  );

endmodule

// ==== fast_intr_ctrl.sv ====
// Fast interrupt controller with sticky pending bits and an enable mask.
// Software clears pending lines by writing ones to the clear register.

`timescale 1ns/100ps

module fast_intr_ctrl #(
  parameter int unsigned NumFastIntr = 15
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  bus_pkg::reg_req_t      reg_req_i,
  output bus_pkg::reg_rsp_t      reg_rsp_o,

  input  logic [NumFastIntr-1:0] fast_intr_i,
  output logic [NumFastIntr-1:0] fast_intr_o
);

  import ao_map_pkg::*;

  logic [11:0]            ofs;
  logic                   wr;
  logic [NumFastIntr-1:0] clr;
  logic [NumFastIntr-1:0] pending_q;
  logic [NumFastIntr-1:0] enable_q;

  assign ofs = reg_req_i.addr[11:0];
  assign wr  = reg_req_i.valid && reg_req_i.write;
  assign clr = (wr && ofs == FI_CLEAR_OFS) ? reg_req_i.wdata[NumFastIntr-1:0] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
      enable_q  <= '1;
    end else begin
      // Set has priority over a same-cycle clear
      pending_q <= (pending_q & ~clr) | fast_intr_i;
      if (wr && ofs == FI_ENABLE_OFS) begin
        enable_q <= reg_req_i.wdata[NumFastIntr-1:0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (ofs)
      FI_PENDING_OFS: begin
        reg_rsp_o.rdata = 32'(pending_q);
        reg_rsp_o.error = reg_req_i.write;
      end
      FI_CLEAR_OFS:  reg_rsp_o.rdata = '0;
      FI_ENABLE_OFS: reg_rsp_o.rdata = 32'(enable_q);
      default:       reg_rsp_o.error = 1'b1;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

// ==== boot_rom.sv ====
// Read-only boot code table on the register bus.
// Word index comes from address bits 5:2; writes are rejected with an error.

`timescale 1ns/100ps

module boot_rom (
  input  bus_pkg::reg_req_t  reg_req_i,
  output bus_pkg::reg_rsp_t  reg_rsp_o
);

  import ao_map_pkg::*;

  logic [3:0] word_idx;
  logic       in_range;

  assign word_idx = reg_req_i.addr[5:2];

  // Anything above the last word reads as zero
  assign in_range = (reg_req_i.addr[11:6] == '0);

  always_comb begin
    if (in_range) begin
      reg_rsp_o.rdata = BOOT_ROM_CONTENT[word_idx];
    end else begin
      reg_rsp_o.rdata = '0;
    end
  end

  assign reg_rsp_o.error = reg_req_i.write;

endmodule

// ==== soc_ctrl.sv ====
// SoC control registers: exit status, boot address and boot-select capture.
// Sits on the register bus and answers in the same cycle.

`timescale 1ns/100ps

module soc_ctrl (
  input  logic               clk_i,
  input  logic               arst_n_i,

  input  bus_pkg::reg_req_t  reg_req_i,
  output bus_pkg::reg_rsp_t  reg_rsp_o,

  input  logic               boot_select_i,
  output logic               exit_valid_o,
  output logic [31:0]        exit_value_o
);

  import ao_map_pkg::*;

  logic [11:0] ofs;
  logic        wr;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] boot_addr_q;
  logic        boot_sel_q;

  function automatic logic [31:0] merge_bytes(logic [31:0] old_val, logic [31:0] new_val,
                                              logic [3:0] strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  assign ofs = reg_req_i.addr[11:0];
  assign wr  = reg_req_i.valid && reg_req_i.write;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      boot_addr_q  <= BOOT_ADDR_RESET;
      boot_sel_q   <= 1'b0;
    end else begin
      boot_sel_q <= boot_select_i;
      if (wr) begin
        case (ofs)
          EXIT_VALID_OFS: if (reg_req_i.wstrb[0]) exit_valid_q <= reg_req_i.wdata[0];
          EXIT_VALUE_OFS: exit_value_q <= merge_bytes(exit_value_q, reg_req_i.wdata,
                                                      reg_req_i.wstrb);
          BOOT_ADDR_OFS:  boot_addr_q  <= merge_bytes(boot_addr_q, reg_req_i.wdata,
                                                      reg_req_i.wstrb);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (ofs)
      EXIT_VALID_OFS: reg_rsp_o.rdata = {31'b0, exit_valid_q};
      EXIT_VALUE_OFS: reg_rsp_o.rdata = exit_value_q;
      BOOT_ADDR_OFS:  reg_rsp_o.rdata = boot_addr_q;
      BOOT_SEL_OFS: begin
        reg_rsp_o.rdata = {31'b0, boot_sel_q};
        reg_rsp_o.error = reg_req_i.write;
      end
      default: reg_rsp_o.error = 1'b1;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// ==== reg_demux.sv ====
// Register-bus address decoder and demultiplexer.
// Routes each access to the target whose page matches, errors on unmapped ones.

`timescale 1ns/100ps

module reg_demux (
  input  bus_pkg::reg_req_t                               in_req_i,
  output bus_pkg::reg_rsp_t                               in_rsp_o,

  output bus_pkg::reg_req_t [ao_map_pkg::NUM_AO_TARGETS-1:0] out_req_o,
  input  bus_pkg::reg_rsp_t [ao_map_pkg::NUM_AO_TARGETS-1:0] out_rsp_i
);

  import bus_pkg::*;
  import ao_map_pkg::*;

  logic       in_region;
  logic [3:0] page;
  logic       hit;
  ao_sel_t    sel;

  assign in_region = (in_req_i.addr[31:16] == AO_BASE_ADDR[31:16]);
  assign page      = in_req_i.addr[15:12];
  assign hit       = in_region && (page < 4'(NUM_AO_TARGETS));
  assign sel       = ao_sel_t'(page);

  // Only the selected target sees valid
  always_comb begin
    for (int unsigned i = 0; i < NUM_AO_TARGETS; i++) begin
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = in_req_i.valid && hit && (sel == ao_sel_t'(i));
    end
  end

  always_comb begin
    if (hit) begin
      in_rsp_o = out_rsp_i[sel];
    end else begin
      in_rsp_o.error = 1'b1;
      in_rsp_o.rdata = UNMAPPED_RDATA;
    end
  end

endmodule

// ==== obi_to_reg.sv ====
// OBI slave to register-bus bridge.
// Grants every request at once; the answer returns with rvalid one cycle later.

`timescale 1ns/100ps

module obi_to_reg (
  input  logic                clk_i,
  input  logic                arst_n_i,

  input  bus_pkg::obi_req_t   obi_req_i,
  output bus_pkg::obi_resp_t  obi_resp_o,

  output bus_pkg::reg_req_t   reg_req_o,
  input  bus_pkg::reg_rsp_t   reg_rsp_i
);

  import bus_pkg::*;

  logic     rvalid_q;
  reg_rsp_t rsp_q;

  // No wait states on the register side
  assign obi_resp_o.gnt = obi_req_i.req;

  assign reg_req_o.valid = obi_req_i.req;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.wstrb = obi_req_i.be;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
    end
  end

  // Capture the target answer in the granting cycle
  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rsp_q <= reg_rsp_i;
    end
  end

  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.err    = rsp_q.error;
  assign obi_resp_o.rdata  = rsp_q.rdata;

endmodule

// ==== ao_map_pkg.sv ====
// Address map of the always-on subsystem.
// Holds target indices, register offsets, reset values and the boot ROM image.

package ao_map_pkg;

  // 64 KiB region, bits 31:16 select the subsystem
  localparam logic [31:0] AO_BASE_ADDR = 32'h2000_0000;

  localparam int unsigned NUM_AO_TARGETS = 4;

  typedef logic [1:0] ao_sel_t;

  // Page number in bits 15:12 equals the target index
  localparam ao_sel_t SOC_CTRL_IDX       = 2'd0;
  localparam ao_sel_t BOOTROM_IDX        = 2'd1;
  localparam ao_sel_t FAST_INTR_CTRL_IDX = 2'd2;
  localparam ao_sel_t EXT_PERIPH_IDX     = 2'd3;

  localparam logic [11:0] EXIT_VALID_OFS = 12'h000;
  localparam logic [11:0] EXIT_VALUE_OFS = 12'h004;
  localparam logic [11:0] BOOT_ADDR_OFS  = 12'h008;
  localparam logic [11:0] BOOT_SEL_OFS   = 12'h00C;

  localparam logic [11:0] FI_PENDING_OFS = 12'h000;
  localparam logic [11:0] FI_CLEAR_OFS   = 12'h004;
  localparam logic [11:0] FI_ENABLE_OFS  = 12'h008;

  localparam logic [31:0] BOOT_ADDR_RESET = 32'h0000_0180;

  localparam int unsigned BOOT_ROM_WORDS = 16;

  // Reads the SoC control page and jumps to the boot address
  localparam logic [31:0] BOOT_ROM_CONTENT [BOOT_ROM_WORDS] = '{
    32'h2000_02B7, 32'h00C2_A303, 32'h0003_1663, 32'h0082_A383,
    32'h0003_8067, 32'h1050_0073, 32'hFFDF_F06F, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013,
    32'h0000_0013, 32'h0000_0013, 32'h0000_0013, 32'h0000_0013
  };

  localparam logic [31:0] UNMAPPED_RDATA = 32'hBADC_AB1E;

endpackage

// ==== bus_pkg.sv ====
// Bus types for the always-on subsystem.
// OBI carries CPU transfers, the register bus carries single-cycle target accesses.

package bus_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  // Targets are always ready, so no ready field
  typedef struct packed {
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

endpackage
